//--- run.sh
#!/usr/bin/env bash
# compile and run the object line table testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -j 0 \
    --top-module tb_obj_line_top -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_obj_line_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

//--- source/obj_bank_mapper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// code bank offset and mask lookup
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module obj_bank_mapper (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] bank_offset,
    input  logic [15:0] bank_mask,
    input  logic [1:0]  cin,
    output logic [3:0]  offset,
    output logic [3:0]  mask
);

    logic [3:0] sel_offset;
    logic [3:0] sel_mask;

    // one nibble per bank, bank 0 in the low bits
    assign sel_offset = bank_offset[{cin, 2'b00} +: 4];
    assign sel_mask   = bank_mask[{cin, 2'b00} +: 4];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            offset <= 4'd0;
            mask   <= 4'd0;
        end else begin
            offset <= sel_offset;
            mask   <= sel_mask;
        end
    end

endmodule

//--- source/obj_frame_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame table RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module obj_frame_ram (
    input  logic                         clk,
    input  logic                         tbl_we,
    input  logic [obj_pkg::FRAME_AW-1:0] tbl_addr,
    input  logic [15:0]                  tbl_data,
    input  logic [obj_pkg::FRAME_AW-1:0] frame_addr,
    output logic [15:0]                  frame_data
);

    logic [15:0] mem [0:obj_pkg::FRAME_WORDS-1];

    // host side, one word per cycle
    always_ff @(posedge clk) begin
        if (tbl_we) begin
            mem[tbl_addr] <= tbl_data;
        end
    end

    always_ff @(posedge clk) begin
        frame_data <= mem[frame_addr];  // builder sees it next cycle
    end

endmodule

//--- source/obj_line_buf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// double buffered line table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module obj_line_buf (
    input  logic              clk,
    obj_line_if.buffer        wr,
    input  logic              render_lsb,
    input  logic [8:0]        line_addr,
    output logic [15:0]       line_data
);

    logic [15:0] mem [0:obj_pkg::LINE_WORDS-1];
    logic [9:0]  wr_addr;
    logic [9:0]  rd_addr;

    assign wr_addr = {wr.half, wr.slot, wr.word};
    assign rd_addr = {~render_lsb, line_addr};  // renderer gets the other half

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr_addr] <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        line_data <= mem[rd_addr];
    end

endmodule

//--- source/obj_line_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line table write channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface obj_line_if;

    logic                      we;
    logic                      half;  // which line buffer half
    logic [obj_pkg::SLOT_W-1:0] slot;
    logic [1:0]                word;
    logic [15:0]               data;

    modport writer (
        output we,
        output half,
        output slot,
        output word,
        output data
    );

    modport buffer (
        input we,
        input half,
        input slot,
        input word,
        input data
    );

endinterface

//--- source/obj_line_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scanline object table builder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module obj_line_table (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [8:0]                   vrender,
    input  logic                         start,
    input  logic [15:0]                  bank_offset,
    input  logic [15:0]                  bank_mask,
    output logic [obj_pkg::FRAME_AW-1:0] frame_addr,
    input  logic [15:0]                  frame_data,
    obj_line_if.writer                   lw,
    output logic                         busy,
    output logic                         done
);

    logic [obj_pkg::ST_W-1:0]    state;
    logic [obj_pkg::ENTRY_W-1:0] entry;
    logic [obj_pkg::SLOT_W-1:0]  slot;
    logic [1:0]                  fword;
    logic                        first;
    logic [3:0]                  n;
    logic [3:0]                  npos;
    logic [3:0]                  npos_step;

    logic [15:0]                 obj_x;
    logic [15:0]                 obj_y;
    logic [15:0]                 obj_code;
    obj_pkg::obj_attr_u          obj_attr;
    logic [15:0]                 last_x;
    logic [15:0]                 last_y;
    logic [15:0]                 last_code;
    logic [15:0]                 last_attr;

    logic [3:0]                  map_offset;
    logic [3:0]                  map_mask;
    logic                        inzone;
    logic [3:0]                  row;
    logic [3:0]                  vsub;
    logic [15:0]                 eff_x;
    logic [15:0]                 word1;
    logic                        in_win;
    logic                        repeated;
    logic                        last_tile;

    // code is held for the whole entry, so the mapper output settles early
    obj_bank_mapper u_mapper (
        .clk         (clk),
        .rst         (rst),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask),
        .cin         (obj_code[15:14]),
        .offset      (map_offset),
        .mask        (map_mask)
    );

    obj_zone u_zone (
        .vrender (vrender),
        .obj_y   (obj_y[8:0]),
        .attr    (obj_attr),
        .inzone  (inzone),
        .row     (row),
        .vsub    (vsub)
    );

    assign eff_x     = obj_x + {8'd0, npos, 4'd0};
    assign in_win    = (eff_x > obj_pkg::X_MIN) && (eff_x < obj_pkg::X_MAX);
    assign last_tile = (n == obj_attr.f.tile_n);
    assign npos_step = obj_attr.f.hflip ? npos - 4'd1 : npos + 4'd1;
    assign repeated  = (obj_x == last_x) && (obj_y == last_y) &&
                       (obj_code == last_code) && (obj_attr.raw == last_attr);

    assign word1 = {(obj_code[15:12] & map_mask) | map_offset,
                    obj_code[11:8],
                    obj_code[7:4] + row,
                    obj_code[3:0] + n};

    // line writes straight from the state
    always_comb begin
        lw.half = vrender[0];
        lw.slot = slot;
        lw.we   = 1'b0;
        lw.word = obj_pkg::SW_ATTR;
        lw.data = obj_pkg::FILL_WORD;
        case (state)
            obj_pkg::ST_W0: begin
                lw.we   = in_win;  // off-window tiles are dropped
                lw.data = {4'd0, vsub, obj_attr.raw[7:0]};
            end
            obj_pkg::ST_W1: begin
                lw.we   = 1'b1;
                lw.word = obj_pkg::SW_CODE;
                lw.data = word1;
            end
            obj_pkg::ST_W2: begin
                lw.we   = 1'b1;
                lw.word = obj_pkg::SW_X;
                lw.data = eff_x;
            end
            obj_pkg::ST_FILL: begin
                lw.we   = 1'b1;
                lw.word = fword;
            end
            default: begin
                lw.we = 1'b0;
            end
        endcase
    end

    // entry words land one cycle after their address
    always_ff @(posedge clk) begin
        case (state)
            obj_pkg::ST_A1: obj_attr.raw <= frame_data;
            obj_pkg::ST_A2: obj_code     <= frame_data;
            obj_pkg::ST_A3: obj_y        <= frame_data;
            obj_pkg::ST_A4: obj_x        <= frame_data;
            obj_pkg::ST_CHECK: begin
                last_x    <= obj_x;  // reference for the next entry
                last_y    <= obj_y;
                last_code <= obj_code;
                last_attr <= obj_attr.raw;
            end
            default: begin
                last_x <= last_x;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= obj_pkg::ST_IDLE;
            busy       <= 1'b0;
            done       <= 1'b0;
            first      <= 1'b0;
            entry      <= '0;
            slot       <= '0;
            fword      <= 2'd0;
            n          <= 4'd0;
            npos       <= 4'd0;
            frame_addr <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                obj_pkg::ST_IDLE: begin
                    if (start) begin
                        busy       <= 1'b1;
                        first      <= 1'b1;
                        slot       <= '0;
                        fword      <= 2'd0;
                        entry      <= obj_pkg::LAST_ENTRY;
                        frame_addr <= obj_pkg::frame_addr_of(obj_pkg::LAST_ENTRY,
                                                             obj_pkg::W_ATTR);
                        state      <= obj_pkg::ST_A0;
                    end
                end
                obj_pkg::ST_A0: begin
                    frame_addr <= obj_pkg::frame_addr_of(entry, obj_pkg::W_CODE);
                    state      <= obj_pkg::ST_A1;
                end
                obj_pkg::ST_A1: begin
                    frame_addr <= obj_pkg::frame_addr_of(entry, obj_pkg::W_Y);
                    state      <= obj_pkg::ST_A2;
                end
                obj_pkg::ST_A2: begin
                    frame_addr <= obj_pkg::frame_addr_of(entry, obj_pkg::W_X);
                    state      <= obj_pkg::ST_A3;
                end
                obj_pkg::ST_A3: state <= obj_pkg::ST_A4;
                obj_pkg::ST_A4: state <= obj_pkg::ST_CHECK;
                obj_pkg::ST_CHECK: begin
                    first <= 1'b0;
                    n     <= 4'd0;
                    npos  <= obj_attr.f.hflip ? obj_attr.f.tile_n : 4'd0;
                    if (inzone && (first || !repeated)) begin
                        state <= obj_pkg::ST_W0;
                    end else begin
                        state <= obj_pkg::ST_NEXT;
                    end
                end
                obj_pkg::ST_W0: begin
                    if (in_win) begin
                        state <= obj_pkg::ST_W1;
                    end else if (last_tile) begin
                        state <= obj_pkg::ST_NEXT;
                    end else begin
                        n    <= n + 4'd1;
                        npos <= npos_step;
                    end
                end
                obj_pkg::ST_W1: state <= obj_pkg::ST_W2;
                obj_pkg::ST_W2: begin
                    if (slot == obj_pkg::LAST_SLOT) begin
                        busy  <= 1'b0;  // line full, no fill
                        done  <= 1'b1;
                        state <= obj_pkg::ST_IDLE;
                    end else begin
                        slot <= slot + 1'b1;
                        if (last_tile) begin
                            state <= obj_pkg::ST_NEXT;
                        end else begin
                            n     <= n + 4'd1;
                            npos  <= npos_step;
                            state <= obj_pkg::ST_W0;
                        end
                    end
                end
                obj_pkg::ST_NEXT: begin
                    if (entry == '0) begin
                        state <= obj_pkg::ST_FILL;
                    end else begin
                        entry      <= entry - 1'b1;
                        frame_addr <= obj_pkg::frame_addr_of(entry - 1'b1, obj_pkg::W_ATTR);
                        state      <= obj_pkg::ST_A0;
                    end
                end
                obj_pkg::ST_FILL: begin
                    fword <= fword + 2'd1;
                    if (fword == obj_pkg::SW_X) begin
                        fword <= 2'd0;
                        if (slot == obj_pkg::LAST_SLOT) begin
                            busy  <= 1'b0;
                            done  <= 1'b1;
                            state <= obj_pkg::ST_IDLE;
                        end else begin
                            slot <= slot + 1'b1;
                        end
                    end
                end
                default: state <= obj_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

//--- source/obj_line_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// object line subsystem top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module obj_line_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         tbl_we,
    input  logic [obj_pkg::FRAME_AW-1:0] tbl_addr,
    input  logic [15:0]                  tbl_data,
    input  logic [8:0]                   vrender,
    input  logic                         start,
    input  logic [15:0]                  bank_offset,
    input  logic [15:0]                  bank_mask,
    input  logic [8:0]                   line_addr,
    output logic [15:0]                  line_data,
    output logic                         busy,
    output logic                         done
);

    logic [obj_pkg::FRAME_AW-1:0] frame_addr;
    logic [15:0]                  frame_data;

    obj_line_if u_lif ();

    obj_frame_ram u_ram (
        .clk        (clk),
        .tbl_we     (tbl_we),
        .tbl_addr   (tbl_addr),
        .tbl_data   (tbl_data),
        .frame_addr (frame_addr),
        .frame_data (frame_data)
    );

    obj_line_table u_table (
        .clk         (clk),
        .rst         (rst),
        .vrender     (vrender),
        .start       (start),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask),
        .frame_addr  (frame_addr),
        .frame_data  (frame_data),
        .lw          (u_lif.writer),
        .busy        (busy),
        .done        (done)
    );

    // renderer reads the half not being built
    obj_line_buf u_buf (
        .clk        (clk),
        .wr         (u_lif.buffer),
        .render_lsb (vrender[0]),
        .line_addr  (line_addr),
        .line_data  (line_data)
    );

endmodule

//--- source/obj_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// object line table sizes, attribute word union
// and frame table address helper
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package obj_pkg;

    localparam int FRAME_WORDS = 1024;
    localparam int FRAME_AW    = $clog2(FRAME_WORDS);
    localparam int OBJ_ENTRIES = 256;
    localparam int ENTRY_W     = $clog2(OBJ_ENTRIES);
    localparam int LINE_SLOTS  = 128;
    localparam int SLOT_W      = $clog2(LINE_SLOTS);
    localparam int LINE_WORDS  = 2 * LINE_SLOTS * 4;  // both halves

    localparam logic [ENTRY_W-1:0] LAST_ENTRY = ENTRY_W'(OBJ_ENTRIES - 1);
    localparam logic [SLOT_W-1:0]  LAST_SLOT  = SLOT_W'(LINE_SLOTS - 1);

    // visible x window, bounds excluded
    localparam logic [15:0] X_MIN     = 16'h0030;
    localparam logic [15:0] X_MAX     = 16'd448;
    localparam logic [15:0] FILL_WORD = 16'hffff;

    // word order inside a frame table entry
    localparam logic [1:0] W_X    = 2'd0;
    localparam logic [1:0] W_Y    = 2'd1;
    localparam logic [1:0] W_CODE = 2'd2;
    localparam logic [1:0] W_ATTR = 2'd3;

    // word order inside a line slot, word3 unused
    localparam logic [1:0] SW_ATTR = 2'd0;
    localparam logic [1:0] SW_CODE = 2'd1;
    localparam logic [1:0] SW_X    = 2'd2;

    // builder FSM encoding
    localparam int ST_W = 4;
    localparam logic [ST_W-1:0] ST_IDLE  = 4'd0;
    localparam logic [ST_W-1:0] ST_A0    = 4'd1;
    localparam logic [ST_W-1:0] ST_A1    = 4'd2;
    localparam logic [ST_W-1:0] ST_A2    = 4'd3;
    localparam logic [ST_W-1:0] ST_A3    = 4'd4;
    localparam logic [ST_W-1:0] ST_A4    = 4'd5;
    localparam logic [ST_W-1:0] ST_CHECK = 4'd6;
    localparam logic [ST_W-1:0] ST_W0    = 4'd7;
    localparam logic [ST_W-1:0] ST_W1    = 4'd8;
    localparam logic [ST_W-1:0] ST_W2    = 4'd9;
    localparam logic [ST_W-1:0] ST_NEXT  = 4'd10;
    localparam logic [ST_W-1:0] ST_FILL  = 4'd11;

    typedef struct packed {
        logic [3:0] tile_m;  // vertical tiles minus one
        logic [3:0] tile_n;  // horizontal tiles minus one
        logic       rsv;
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;
    } obj_attr_s;

    typedef union packed {
        obj_attr_s   f;
        logic [15:0] raw;
    } obj_attr_u;

    function automatic logic [FRAME_AW-1:0] frame_addr_of(
        input logic [ENTRY_W-1:0] entry,
        input logic [1:0]         word
    );
        return {entry, word};
    endfunction

endpackage

//--- source/obj_zone.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vertical zone test, row and sub-line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module obj_zone (
    input  logic [8:0]         vrender,
    input  logic [8:0]         obj_y,
    input  obj_pkg::obj_attr_u attr,
    output logic               inzone,
    output logic [3:0]         row,
    output logic [3:0]         vsub
);

    logic [8:0]  diff;
    logic [15:0] match;
    logic [3:0]  idx;

    assign diff = vrender - obj_y;  // wraps at 512 lines

    // row m covers lines 16m to 16m+15 of the object
    always_comb begin
        for (int m = 0; m < 16; m++) begin
            match[m] = (4'(m) <= attr.f.tile_m) && (diff[8:4] == 5'(m));
        end
    end

    // at most one bit set
    always_comb begin
        idx = 4'd0;
        for (int m = 0; m < 16; m++) begin
            if (match[m]) begin
                idx = 4'(m);
            end
        end
    end

    assign inzone = |match;
    assign row    = attr.f.vflip ? attr.f.tile_m - idx : idx;
    assign vsub   = diff[3:0] ^ {4{attr.f.vflip}};  // mirrored inside the tile

endmodule

//--- tb/tb_obj_line_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the object line subsystem
// reference line model, stimulus, checker and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_obj_line_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS      = 4;
    localparam int READ_WORDS  = 3 * obj_pkg::LINE_SLOTS;  // words 0 to 2 of every slot
    localparam int BUILD_LIMIT = 3000;                     // worst case build in cycles
    localparam int PASS_NS     = (obj_pkg::FRAME_WORDS + BUILD_LIMIT + 512) * CLK_NS;
    localparam int WATCHDOG_NS = 14 * PASS_NS;             // seven passes, twice over

    logic        clk;
    logic        rst;
    logic        tbl_we;
    logic [9:0]  tbl_addr;
    logic [15:0] tbl_data;
    logic [8:0]  vrender;
    logic        start;
    logic [15:0] bank_offset;
    logic [15:0] bank_mask;
    logic [8:0]  line_addr;
    logic [15:0] line_data;
    logic        busy;
    logic        done;

    logic [15:0] frame [obj_pkg::FRAME_WORDS];  // host copy of the frame table
    logic [15:0] exp_a [READ_WORDS];
    logic [15:0] exp_b [READ_WORDS];
    integer      seed = 32'h398c;
    int          word_errors = 0;
    int          misc_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    // readback pipeline, compared one cycle after the registered read
    logic        chk_valid;
    logic [15:0] chk_exp;
    logic        chk_valid_d = 1'b0;
    logic [15:0] chk_exp_d = 16'd0;
    logic [8:0]  chk_addr_d = 9'd0;

    obj_line_top uut (
        .clk         (clk),
        .rst         (rst),
        .tbl_we      (tbl_we),
        .tbl_addr    (tbl_addr),
        .tbl_data    (tbl_data),
        .vrender     (vrender),
        .start       (start),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask),
        .line_addr   (line_addr),
        .line_data   (line_data),
        .busy        (busy),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (chk_valid_d && line_data !== chk_exp_d) begin
            $display("ERR %0d ns: line_data at addr %0d expected %h, got %h",
                     $time, chk_addr_d, chk_exp_d, line_data);
            word_errors++;
        end
        chk_valid_d <= chk_valid;
        chk_exp_d   <= chk_exp;
        chk_addr_d  <= line_addr;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    // expected slot words of one line, from the line table rules
    function automatic void ref_line(
        input  logic [15:0] tbl [obj_pkg::FRAME_WORDS],
        input  logic [8:0]  vr,
        input  logic [15:0] bo,
        input  logic [15:0] bm,
        output logic [15:0] exp_w [READ_WORDS]
    );
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] code;
        logic [15:0] attr;
        logic [63:0] prev;
        logic        have_prev;
        logic [8:0]  diff;
        logic [3:0]  row;
        logic [3:0]  vsub;
        logic [3:0]  off;
        logic [3:0]  msk;
        logic [15:0] ex;
        int          tm;
        int          tn;
        int          npos;
        int          slot;
        slot      = 0;
        have_prev = 1'b0;
        prev      = '0;
        for (int k = obj_pkg::OBJ_ENTRIES - 1; k >= 0; k--) begin
            x    = tbl[4*k];
            y    = tbl[4*k+1];
            code = tbl[4*k+2];
            attr = tbl[4*k+3];
            diff = vr - y[8:0];
            tm   = int'(attr[15:12]);
            tn   = int'(attr[11:8]);
            if (slot < obj_pkg::LINE_SLOTS && int'(diff) / 16 <= tm &&
                !(have_prev && prev == {x, y, code, attr})) begin
                row  = attr[6] ? 4'(tm - int'(diff) / 16) : 4'(int'(diff) / 16);
                vsub = attr[6] ? 4'(15 - int'(diff) % 16) : 4'(int'(diff) % 16);
                off  = 4'(bo >> (4 * code[15:14]));  // bank picked by code top bits
                msk  = 4'(bm >> (4 * code[15:14]));
                for (int n = 0; n <= tn; n++) begin
                    npos = attr[5] ? tn - n : n;
                    ex   = x + 16'(16 * npos);
                    if (slot < obj_pkg::LINE_SLOTS && ex > 16'h0030 && ex < 16'd448) begin
                        exp_w[3*slot]   = {4'd0, vsub, attr[7:0]};
                        exp_w[3*slot+1] = {(code[15:12] & msk) | off, code[11:8],
                                           code[7:4] + row, code[3:0] + 4'(n)};
                        exp_w[3*slot+2] = ex;
                        slot++;
                    end
                end
            end
            prev      = {x, y, code, attr};  // compared even when skipped
            have_prev = 1'b1;
        end
        for (int i = 3 * slot; i < READ_WORDS; i++) begin
            exp_w[i] = 16'hffff;
        end
    endfunction

    function automatic logic [15:0] rnd16();
        return 16'($random(seed));
    endfunction

    function automatic int rnd_below(input int lim);
        return int'({1'b0, rnd16()}) % lim;
    endfunction

    function automatic logic [15:0] pack_attr(
        input logic [3:0] tm,
        input logic [3:0] tn,
        input logic       vflip,
        input logic       hflip,
        input logic [4:0] pal
    );
        return {tm, tn, 1'b0, vflip, hflip, pal};
    endfunction

    function automatic void set_entry(
        input int          k,
        input logic [15:0] x,
        input logic [15:0] y,
        input logic [15:0] code,
        input logic [15:0] attr
    );
        frame[4*k]   = x;
        frame[4*k+1] = y;
        frame[4*k+2] = code;
        frame[4*k+3] = attr;
    endfunction

    function automatic void copy_entry(input int dst, input int src);
        for (int w = 0; w < 4; w++) begin
            frame[4*dst+w] = frame[4*src+w];
        end
    endfunction

    // difference of 256 lines is past any object height
    function automatic logic [15:0] far_y(input logic [8:0] vr);
        logic [15:0] r;
        r = rnd16();
        return {r[15:9], vr + 9'd256};
    endfunction

    // y placing vr within the first depth lines of the object
    function automatic logic [15:0] in_y(input logic [8:0] vr, input int depth);
        logic [15:0] r;
        r = rnd16();
        return {r[15:9], vr - 9'(rnd_below(depth))};
    endfunction

    function automatic void far_table(input logic [8:0] vr);
        for (int k = 0; k < obj_pkg::OBJ_ENTRIES; k++) begin
            set_entry(k, rnd16(), far_y(vr), rnd16(), rnd16());
        end
    endfunction

    function automatic void put_visible(input int k, input logic [8:0] vr);
        logic [15:0] r;
        r = rnd16();
        set_entry(k, 16'(64 + rnd_below(192)), in_y(vr, 16 * (int'(r[11:8]) + 1)),
                  rnd16(), pack_attr(r[11:8], {2'b00, r[13:12]}, r[0], r[1], r[6:2]));
    endfunction

    function automatic int total_errors();
        return word_errors + misc_errors;
    endfunction

    task automatic new_banks();
        @(negedge clk);
        bank_offset = rnd16();
        bank_mask   = rnd16();
    endtask

    task automatic load_table();
        for (int i = 0; i < obj_pkg::FRAME_WORDS; i++) begin
            @(negedge clk);
            tbl_we   = 1'b1;
            tbl_addr = 10'(i);
            tbl_data = frame[i];
        end
        @(negedge clk);
        tbl_we = 1'b0;
    endtask

    task automatic run_build(input logic [8:0] vr, output int cycles);
        @(negedge clk);
        vrender = vr;
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (!busy) begin
            $display("busy did not rise after start");
            misc_errors++;
        end
        cycles = 0;
        while (!done && cycles < BUILD_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (done) begin
            if (busy) begin
                $display("busy still high in the cycle of done");
                misc_errors++;
            end
            @(negedge clk);
            if (done) begin
                $display("done stayed high for more than one cycle");
                misc_errors++;
            end
        end else begin
            $display("build did not finish within %0d cycles", BUILD_LIMIT);
            misc_errors++;
        end
    endtask

    task automatic read_line(input logic [15:0] exp_w [READ_WORDS]);
        for (int s = 0; s < obj_pkg::LINE_SLOTS; s++) begin
            for (int w = 0; w < 3; w++) begin
                @(negedge clk);
                line_addr = {7'(s), 2'(w)};
                chk_exp   = exp_w[3*s+w];
                chk_valid = 1'b1;
            end
        end
        @(negedge clk);
        chk_valid = 1'b0;
        repeat (2) @(negedge clk);  // drain the read pipeline
    endtask

    task automatic build_and_check(input logic [8:0] vr, output int cycles);
        new_banks();
        ref_line(frame, vr, bank_offset, bank_mask, exp_a);
        load_table();
        run_build(vr, cycles);
        @(negedge clk);
        vrender = vr + 9'd1;  // flips the read half onto the new line
        read_line(exp_a);
    endtask

    task automatic report(input int num, input string name, input int e0);
        tests_run++;
        if (total_errors() == e0) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", num, name, total_errors() - e0);
        end
    endtask

    initial begin
        logic [15:0] r;
        logic [15:0] x;
        logic [3:0]  tm;
        logic [3:0]  tn;
        int          e0;
        int          build_cycles;
        rst         = 1'b1;
        tbl_we      = 1'b0;
        tbl_addr    = '0;
        tbl_data    = '0;
        vrender     = '0;
        start       = 1'b0;
        bank_offset = '0;
        bank_mask   = '0;
        line_addr   = '0;
        chk_valid   = 1'b0;
        chk_exp     = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        e0 = total_errors();
        if (busy !== 1'b0 || done !== 1'b0) begin
            $display("busy or done not low after reset");
            misc_errors++;
        end
        far_table(9'd100);
        build_and_check(9'd100, build_cycles);
        report(1, "reset and empty table", e0);

        // tile_m 0 with diff up to 31, so about half are in zone
        e0 = total_errors();
        far_table(9'd37);
        for (int i = 0; i < 40; i++) begin
            r = rnd16();
            set_entry(10 + 6 * i, 16'(rnd_below(512)), in_y(9'd37, 32), rnd16(),
                      pack_attr(4'd0, 4'd0, r[0], r[1], r[6:2]));
        end
        build_and_check(9'd37, build_cycles);
        report(2, "single tile objects", e0);

        e0 = total_errors();
        far_table(9'd200);
        for (int i = 0; i < 6; i++) begin
            r  = rnd16();
            tm = (i == 0) ? 4'hf : r[11:8];
            tn = (i == 0) ? 4'hf : r[15:12];
            x  = 16'(rnd_below(400));
            if (i == 1) begin
                x = 16'd0;  // left tiles fall on or below X_MIN
            end
            if (i == 2) begin
                x = 16'(448 - 16 * int'(tn));  // right tile lands on X_MAX
            end
            set_entry(250 - 45 * i, x, in_y(9'd200, 16 * (int'(tm) + 1)), rnd16(),
                      pack_attr(tm, tn, i[1], i[0], r[4:0]));
        end
        build_and_check(9'd200, build_cycles);
        report(3, "multi tile objects and flips", e0);

        e0 = total_errors();
        far_table(9'd60);
        put_visible(200, 9'd60);
        copy_entry(199, 200);
        put_visible(150, 9'd60);
        put_visible(149, 9'd60);
        copy_entry(148, 150);  // not adjacent, written again
        put_visible(100, 9'd60);
        copy_entry(99, 100);
        copy_entry(98, 100);
        build_and_check(9'd60, build_cycles);
        report(4, "repeated objects", e0);

        e0 = total_errors();
        far_table(9'd300);
        for (int k = 255; k > 235; k--) begin
            r = rnd16();
            set_entry(k, 16'h0040, in_y(9'd300, 16), rnd16(),
                      pack_attr(r[3:0], 4'hf, r[4], r[5], r[10:6]));
        end
        build_and_check(9'd300, build_cycles);
        // a full scan reads all frame words, one per cycle
        if (build_cycles >= obj_pkg::FRAME_WORDS) begin
            $display("full line did not end the build, it took %0d cycles", build_cycles);
            misc_errors++;
        end
        report(5, "line overflow", e0);

        // second build goes to the other half while the first is read
        e0 = total_errors();
        far_table(9'd10);
        for (int i = 0; i < 8; i++) begin
            put_visible(30 * i + 7, 9'd10);
        end
        new_banks();
        ref_line(frame, 9'd10, bank_offset, bank_mask, exp_a);
        load_table();
        run_build(9'd10, build_cycles);
        @(negedge clk);
        vrender = 9'd11;
        read_line(exp_a);
        far_table(9'd11);
        for (int i = 0; i < 8; i++) begin
            put_visible(30 * i + 20, 9'd11);
        end
        ref_line(frame, 9'd11, bank_offset, bank_mask, exp_b);
        load_table();
        run_build(9'd11, build_cycles);
        read_line(exp_a);
        @(negedge clk);
        vrender = 9'd12;
        read_line(exp_b);
        report(6, "double buffer", e0);

        $display("tests run %0d, failed %0d, word errors %0d, other errors %0d",
                 tests_run, tests_failed, word_errors, misc_errors);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
source/obj_pkg.sv
source/obj_line_if.sv
source/obj_frame_ram.sv
source/obj_bank_mapper.sv
source/obj_zone.sv
source/obj_line_buf.sv
source/obj_line_table.sv
source/obj_line_top.sv
tb/tb_obj_line_top.sv
